//--- src/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [15:0] immT;

    localparam wordT ResetPc = 32'h0000_0000;
    localparam int   NumRegs = 32;

    //////////////////////////////////////////////////
    // instruction encodings
    //////////////////////////////////////////////////
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    // all-zero value is add, so a bubble decodes harmlessly
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluCtrlT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

    //////////////////////////////////////////////////
    // pipeline registers
    //////////////////////////////////////////////////
    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    aluSrcImm;
        aluCtrlT aluCtrl;
    } ctrlT;

    typedef struct packed {
        wordT instr;
        wordT pcPlus4;
    } ifIdRegT;

    typedef struct packed {
        ctrlT   ctrl;
        regIdxT rs;
        regIdxT rt;
        regIdxT wsel;
        wordT   opA;
        wordT   opB;
        wordT   imm;
        wordT   branchTarget;
    } idExRegT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        logic   zero;
        wordT   aluOut;
        wordT   storeData;
        regIdxT wsel;
        wordT   branchTarget;
    } exMemRegT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        wordT   aluOut;
        wordT   loadData;
        regIdxT wsel;
    } memWbRegT;

endpackage

//--- src/registerFile.sv
`timescale 1ns/1ns

module registerFile import mipsPkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   writeEn,
    input  regIdxT writeIdx,
    input  wordT   writeData,
    input  regIdxT readIdxA,
    input  regIdxT readIdxB,
    output wordT   readA,
    output wordT   readB
);

    wordT regs [NumRegs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign readA = (readIdxA == '0) ? '0 :
                   (writeEn && writeIdx == readIdxA) ? writeData : regs[readIdxA];
    assign readB = (readIdxB == '0) ? '0 :
                   (writeEn && writeIdx == readIdxB) ? writeData : regs[readIdxB];

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ns

module fetchStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     loadStall,
    input  logic     flushIfId,
    input  logic     jumpTaken,
    input  wordT     jumpTarget,
    input  exMemRegT exMem,
    output wordAddrT icacheAddr,
    input  wordT     icacheRdata,
    output ifIdRegT  ifId
);

    wordT pc;
    wordT pcPlus4;
    logic branchTaken;

    assign pcPlus4     = pc + 32'd4;
    assign branchTaken = exMem.branch && exMem.zero;
    assign icacheAddr  = pc[31:2];

    // next pc: taken branch beats a stall, jump only when not stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= ResetPc;
        end else if (!freeze) begin
            if (branchTaken) begin
                pc <= exMem.branchTarget;
            end else if (!loadStall) begin
                pc <= jumpTaken ? jumpTarget : pcPlus4;
            end
        end
    end

    //////////////////////////////////////////////////
    // fetch/decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifId <= '0;
        end else if (!freeze) begin
            if (flushIfId) begin
                ifId <= '0;
            end else if (!loadStall) begin
                ifId.instr   <= icacheRdata;
                ifId.pcPlus4 <= pcPlus4;
            end
        end
    end

    // redirect targets come from decode and the execute/memory register
    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ns

module decodeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     loadStall,
    input  logic     flushIdEx,
    input  ifIdRegT  ifId,
    input  memWbRegT memWb,
    input  wordT     wbData,
    output idExRegT  idEx,
    output logic     jumpTaken,
    output wordT     jumpTarget
);

    opcodeT  opcode;
    functT   funct;
    regIdxT  rs;
    regIdxT  rt;
    regIdxT  rd;
    immT     imm;
    wordT    immExt;
    wordT    regA;
    wordT    regB;
    ctrlT    ctrl;
    idExRegT idExNext;

    assign opcode = opcodeT'(ifId.instr[31:26]);
    assign funct  = functT'(ifId.instr[5:0]);
    assign rs     = ifId.instr[25:21];
    assign rt     = ifId.instr[20:16];
    assign rd     = ifId.instr[15:11];
    assign imm    = ifId.instr[15:0];
    assign immExt = {{16{imm[15]}}, imm};

    assign jumpTaken  = (opcode == opJ);
    assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

    //////////////////////////////////////////////////
    // main control
    //////////////////////////////////////////////////
    always_comb begin
        ctrl = '0;
        case (opcode)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd:   ctrl.aluCtrl = aluAdd;
                    fnSub:   ctrl.aluCtrl = aluSub;
                    fnAnd:   ctrl.aluCtrl = aluAnd;
                    fnOr:    ctrl.aluCtrl = aluOr;
                    fnSlt:   ctrl.aluCtrl = aluSlt;
                    // includes the all-zero nop
                    default: ctrl = '0;
                endcase
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.branch  = 1'b1;
                ctrl.aluCtrl = aluSub;
            end
            default: ctrl = '0;
        endcase
    end

    registerFile registerFile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .writeEn   (memWb.regWrite),
        .writeIdx  (memWb.wsel),
        .writeData (wbData),
        .readIdxA  (rs),
        .readIdxB  (rt),
        .readA     (regA),
        .readB     (regB)
    );

    always_comb begin
        idExNext.ctrl         = ctrl;
        idExNext.rs           = rs;
        idExNext.rt           = rt;
        idExNext.wsel         = (opcode == opRtype) ? rd : rt;
        idExNext.opA          = regA;
        idExNext.opB          = regB;
        idExNext.imm          = immExt;
        idExNext.branchTarget = ifId.pcPlus4 + {immExt[29:0], 2'b00};
        // bubble on flush or load-use
        if (flushIdEx || loadStall) begin
            idExNext.ctrl = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!freeze) begin
            idEx <= idExNext;
        end
    end

    // hazard unit must never stall a jump
    noJumpInStall: assert property (@(posedge clk) disable iff (!rst_n)
        loadStall |-> !jumpTaken)
        else $error("jump decoded during load-use stall");

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit import mipsPkg::*; (
    input  wordT     instr,
    input  idExRegT  idEx,
    input  exMemRegT exMem,
    input  logic     jumpTaken,
    input  logic     icacheStall,
    input  logic     dcacheStall,
    output logic     freeze,
    output logic     loadStall,
    output logic     flushIfId,
    output logic     flushIdEx,
    output logic     flushExMem
);

    regIdxT rs;
    regIdxT rt;
    logic   branchTaken;
    logic   useMatch;

    assign rs = instr[25:21];
    assign rt = instr[20:16];

    // either cache busy stops everything
    assign freeze = icacheStall || dcacheStall;

    // a jump reads no registers since its index fields are target bits
    assign useMatch  = idEx.ctrl.memRead && (idEx.rt == rs || idEx.rt == rt);
    assign loadStall = useMatch && !jumpTaken;

    assign branchTaken = exMem.branch && exMem.zero;
    assign flushIfId   = branchTaken || jumpTaken;
    assign flushIdEx   = branchTaken;
    assign flushExMem  = branchTaken;

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ns

module executeStage import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  logic     flushExMem,
    input  idExRegT  idEx,
    input  memWbRegT memWb,
    input  wordT     wbData,
    output exMemRegT exMem
);

    fwdSelT fwdA;
    fwdSelT fwdB;
    wordT   opA;
    wordT   opBReg;
    wordT   opB;
    wordT   aluResult;

    // memory stage wins over writeback, it is the younger result
    function automatic fwdSelT pickFwd(regIdxT src);
        if (exMem.regWrite && exMem.wsel != '0 && exMem.wsel == src) begin
            return fwdMem;
        end
        if (memWb.regWrite && memWb.wsel != '0 && memWb.wsel == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    function automatic wordT fwdValue(fwdSelT sel, wordT regVal);
        case (sel)
            fwdMem:  return exMem.aluOut;
            fwdWb:   return wbData;
            default: return regVal;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // operand selection
    //////////////////////////////////////////////////
    always_comb begin
        fwdA   = pickFwd(idEx.rs);
        fwdB   = pickFwd(idEx.rt);
        opA    = fwdValue(fwdA, idEx.opA);
        opBReg = fwdValue(fwdB, idEx.opB);
        opB    = idEx.ctrl.aluSrcImm ? idEx.imm : opBReg;
    end

    // alu
    always_comb begin
        case (idEx.ctrl.aluCtrl)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // execute/memory register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!freeze) begin
            if (flushExMem) begin
                exMem <= '0;
            end else begin
                exMem.regWrite     <= idEx.ctrl.regWrite;
                exMem.memRead      <= idEx.ctrl.memRead;
                exMem.memWrite     <= idEx.ctrl.memWrite;
                exMem.branch       <= idEx.ctrl.branch;
                exMem.zero         <= (aluResult == '0);
                exMem.aluOut       <= aluResult;
                // store data is rt after forwarding, not the immediate
                exMem.storeData    <= opBReg;
                exMem.wsel         <= idEx.wsel;
                exMem.branchTarget <= idEx.branchTarget;
            end
        end
    end

endmodule

//--- src/memWriteback.sv
`timescale 1ns/1ns

module memWriteback import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     freeze,
    input  exMemRegT exMem,
    output logic     dcacheRen,
    output logic     dcacheWen,
    output wordAddrT dcacheAddr,
    output wordT     dcacheWdata,
    input  wordT     dcacheRdata,
    output memWbRegT memWb,
    output wordT     wbData
);

    // data cache driven straight from the execute/memory register
    assign dcacheRen   = exMem.memRead;
    assign dcacheWen   = exMem.memWrite;
    assign dcacheAddr  = exMem.aluOut[31:2];
    assign dcacheWdata = exMem.storeData;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memRead  <= exMem.memRead;
            memWb.aluOut   <= exMem.aluOut;
            memWb.loadData <= dcacheRdata;
            memWb.wsel     <= exMem.wsel;
        end
    end

    // writeback select
    assign wbData = memWb.memRead ? memWb.loadData : memWb.aluOut;

    // decode never sets both for one opcode
    dcacheExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen))
        else $error("data cache read and write in the same cycle");

endmodule

//--- src/mipsPipeline.sv
`timescale 1ns/1ns

module mipsPipeline import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output wordAddrT icacheAddr,
    input  wordT     icacheRdata,
    input  logic     icacheStall,
    output logic     dcacheRen,
    output logic     dcacheWen,
    output wordAddrT dcacheAddr,
    output wordT     dcacheWdata,
    input  wordT     dcacheRdata,
    input  logic     dcacheStall
);

    ifIdRegT  ifId;
    idExRegT  idEx;
    exMemRegT exMem;
    memWbRegT memWb;
    wordT     wbData;
    wordT     jumpTarget;
    logic     jumpTaken;
    logic     freeze;
    logic     loadStall;
    logic     flushIfId;
    logic     flushIdEx;
    logic     flushExMem;

    fetchStage fetchStage_i (
        .clk, .rst_n, .freeze, .loadStall, .flushIfId, .jumpTaken, .jumpTarget,
        .exMem, .icacheAddr, .icacheRdata, .ifId
    );

    decodeStage decodeStage_i (
        .clk, .rst_n, .freeze, .loadStall, .flushIdEx, .ifId, .memWb, .wbData,
        .idEx, .jumpTaken, .jumpTarget
    );

    executeStage executeStage_i (
        .clk, .rst_n, .freeze, .flushExMem, .idEx, .memWb, .wbData, .exMem
    );

    memWriteback memWriteback_i (
        .clk, .rst_n, .freeze, .exMem, .dcacheRen, .dcacheWen, .dcacheAddr,
        .dcacheWdata, .dcacheRdata, .memWb, .wbData
    );

    hazardUnit hazardUnit_i (
        .instr       (ifId.instr),
        .idEx        (idEx),
        .exMem       (exMem),
        .jumpTaken   (jumpTaken),
        .icacheStall (icacheStall),
        .dcacheStall (dcacheStall),
        .freeze      (freeze),
        .loadStall   (loadStall),
        .flushIfId   (flushIfId),
        .flushIdEx   (flushIdEx),
        .flushExMem  (flushExMem)
    );

endmodule

//--- testbench/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

//////////////////////////////////////////////////
// instruction encoding
//////////////////////////////////////////////////
function automatic wordT encR(regIdxT rd, regIdxT rs, regIdxT rt, functT fn);
    return {opRtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic wordT encI(opcodeT op, regIdxT rs, regIdxT rt, immT imm);
    return {op, rs, rt, imm};
endfunction

function automatic wordT encJ(int target);
    return {opJ, 26'(target)};
endfunction

// initial data memory contents, every bit of the index matters
function automatic wordT fillWord(int idx);
    return (wordT'(idx) * 32'h9E37_79B1) ^ 32'hC3A5_0F00;
endfunction

//////////////////////////////////////////////////
// random program pieces
//////////////////////////////////////////////////
function automatic regIdxT randReg();
    return regIdxT'(1 + $urandom_range(6));
endfunction

// lean on the previous destination to provoke forwarding
function automatic regIdxT pickSrc(regIdxT lastDest);
    if ($urandom_range(99) < 50) begin
        return lastDest;
    end
    return randReg();
endfunction

function automatic functT randFunct();
    case ($urandom_range(4))
        0:       return fnAdd;
        1:       return fnSub;
        2:       return fnAnd;
        3:       return fnOr;
        default: return fnSlt;
    endcase
endfunction

// small signed values half the time so slt and beq see near ties
function automatic immT randImm();
    if ($urandom_range(1) == 0) begin
        return immT'(int'($urandom_range(15)) - 8);
    end
    return immT'($urandom);
endfunction

// body data lives below the dump words
function automatic immT dataOffset();
    return immT'(4 * $urandom_range(DumpBase - 1));
endfunction

task automatic genProgram();
    regIdxT lastDest;
    regIdxT dest;
    regIdxT src;
    int     kind;
    int     span;
    lastDest = 5'd1;
    for (int k = 0; k < BodyLen; k++) begin
        kind = int'($urandom_range(99));
        span = (BodyLen - 1 - k < 5) ? BodyLen - 1 - k : 5;
        dest = randReg();
        if (kind < 35) begin
            prog[k] = encR(dest, pickSrc(lastDest), pickSrc(lastDest), randFunct());
            lastDest = dest;
        end else if (kind < 55) begin
            prog[k] = encI(opAddi, pickSrc(lastDest), dest, randImm());
            lastDest = dest;
        end else if (kind < 70) begin
            // base register zero, so the offset is the address
            prog[k] = encI(opLw, 5'd0, dest, dataOffset());
            lastDest = dest;
        end else if (kind < 82) begin
            prog[k] = encI(opSw, 5'd0, pickSrc(lastDest), dataOffset());
        end else if (kind < 92) begin
            src = pickSrc(lastDest);
            // half of the branches compare a register with itself
            prog[k] = encI(opBeq, src, ($urandom_range(1) == 0) ? src : randReg(),
                           immT'($urandom_range(span)));
        end else begin
            prog[k] = encJ(k + 1 + int'($urandom_range(span)));
        end
    end
    // register dump, then the halt loop
    for (int i = 0; i < 7; i++) begin
        prog[BodyLen + i] = encI(opSw, 5'd0, regIdxT'(i + 1), immT'((DumpBase + i) * 4));
    end
    prog[HaltIdx] = encJ(HaltIdx);
    for (int i = HaltIdx + 1; i < ImemWords; i++) begin
        prog[i] = '0;
    end
endtask

//////////////////////////////////////////////////
// instruction-level reference model
//////////////////////////////////////////////////
task automatic runModel();
    wordT regs [NumRegs];
    wordT mem [DataWords];
    wordT instr;
    wordT immExt;
    wordT a;
    wordT b;
    wordT addr;
    int   pc;
    int   steps;
    for (int i = 0; i < NumRegs; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DataWords; i++) begin
        mem[i] = fillWord(i);
    end
    expAddr.delete();
    expData.delete();
    pc = 0;
    steps = 0;
    while (pc != HaltIdx && steps < 1000) begin
        instr  = prog[pc];
        immExt = {{16{instr[15]}}, instr[15:0]};
        a      = regs[instr[25:21]];
        b      = regs[instr[20:16]];
        addr   = a + immExt;
        pc     = pc + 1;
        steps++;
        case (instr[31:26])
            opRtype: begin
                case (instr[5:0])
                    fnAdd:   regs[instr[15:11]] = a + b;
                    fnSub:   regs[instr[15:11]] = a - b;
                    fnAnd:   regs[instr[15:11]] = a & b;
                    fnOr:    regs[instr[15:11]] = a | b;
                    fnSlt:   regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: ;
                endcase
            end
            opAddi:  regs[instr[20:16]] = a + immExt;
            opLw:    regs[instr[20:16]] = mem[addr[7:2]];
            opSw: begin
                mem[addr[7:2]] = b;
                expAddr.push_back(addr[31:2]);
                expData.push_back(b);
            end
            opBeq: begin
                if (a == b) begin
                    pc = pc + int'($signed(instr[15:0]));
                end
            end
            opJ:     pc = int'(instr[25:0]);
            default: ;
        endcase
        regs[0] = '0;
    end
    modelOk = (pc == HaltIdx);
endtask

`endif

//--- testbench/tbMips.sv
`timescale 1ns/1ns

module tbMips import mipsPkg::*; ();

    localparam int ClkPeriod   = 20;
    localparam int NumPrograms = 20;
    localparam int ProgCycles  = 400;
    localparam int BodyLen     = 40;
    localparam int DumpBase    = 56;
    localparam int HaltIdx     = BodyLen + 7;
    localparam int ImemWords   = 64;
    localparam int DataWords   = 64;
    localparam int StallPct    = 20;
    localparam int StallLen    = 1024;

    logic     clk = 1'b0;
    logic     rst_n;
    wordAddrT icacheAddr;
    wordT     icacheRdata;
    logic     icacheStall;
    logic     dcacheRen;
    logic     dcacheWen;
    wordAddrT dcacheAddr;
    wordT     dcacheWdata;
    wordT     dcacheRdata;
    logic     dcacheStall;

    wordT       imem [ImemWords];
    wordT       dmem [DataWords];
    wordT       prog [ImemWords];
    logic [1:0] stallPattern [StallLen];
    wordAddrT   capAddr [$];
    wordT       capData [$];
    wordAddrT   expAddr [$];
    wordT       expData [$];
    logic       haltSeen;
    logic       modelOk;
    int         errorCount = 0;
    int         checkCount = 0;
    int         progErrors = 0;
    int         failedPrograms = 0;

    `include "tbIsaModel.svh"

    always #(ClkPeriod / 2) clk = ~clk;

    mipsPipeline mipsPipeline_i (
        .clk, .rst_n, .icacheAddr, .icacheRdata, .icacheStall, .dcacheRen, .dcacheWen,
        .dcacheAddr, .dcacheWdata, .dcacheRdata, .dcacheStall
    );

    //////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////
    assign icacheRdata = imem[icacheAddr[5:0]];
    // read data idles at zero when no load is in the memory stage
    assign dcacheRdata = dcacheRen ? dmem[dcacheAddr[5:0]] : '0;

    // a write lands only on an edge where the pipeline is not frozen
    always @(posedge clk) begin
        if (!rst_n) begin
            haltSeen <= 1'b0;
            capAddr.delete();
            capData.delete();
            for (int i = 0; i < DataWords; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dcacheWen && !icacheStall && !dcacheStall) begin
            dmem[dcacheAddr[5:0]] <= dcacheWdata;
            capAddr.push_back(dcacheAddr);
            capData.push_back(dcacheWdata);
            if (dcacheAddr == wordAddrT'(DumpBase + 6)) begin
                haltSeen <= 1'b1;
            end
        end
    end

    // stall levels replay a pattern drawn up front
    initial begin : stallDriver
        int stallIdx;
        stallIdx = 0;
        icacheStall <= 1'b0;
        dcacheStall <= 1'b0;
        forever begin
            @(posedge clk);
            {icacheStall, dcacheStall} <= stallPattern[stallIdx];
            stallIdx = (stallIdx + 1) % StallLen;
        end
    end

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic checkAddr(string name, wordAddrT expected, wordAddrT actual);
        checkCount++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
            progErrors++;
        end
    endtask

    task automatic checkWord(string name, wordT expected, wordT actual);
        checkCount++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
            progErrors++;
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        checkCount++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            errorCount++;
            progErrors++;
        end
    endtask

    task automatic compareStores(int p);
        int n;
        n = (capAddr.size() < expAddr.size()) ? capAddr.size() : expAddr.size();
        if (capAddr.size() != expAddr.size()) begin
            $display("program %0d: the DUT made %0d stores but the model made %0d",
                     p, capAddr.size(), expAddr.size());
            errorCount++;
            progErrors++;
        end
        for (int i = 0; i < n; i++) begin
            checkAddr($sformatf("prog%0d store%0d address", p, i), expAddr[i], capAddr[i]);
            checkWord($sformatf("prog%0d store%0d data", p, i), expData[i], capData[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // program runs
    //////////////////////////////////////////////////
    initial begin : mainSeq
        int cycles;
        void'($urandom(32'h06357527));
        rst_n <= 1'b0;
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < StallLen; i++) begin
            stallPattern[i][1] = ($urandom_range(99) < StallPct);
            stallPattern[i][0] = ($urandom_range(99) < StallPct);
        end
        for (int p = 0; p < NumPrograms; p++) begin
            progErrors = 0;
            genProgram();
            runModel();
            if (!modelOk) begin
                $display("program %0d: the model never reached the halt loop", p);
                errorCount++;
                progErrors++;
            end
            @(posedge clk);
            rst_n <= 1'b0;
            @(posedge clk);
            for (int i = 0; i < ImemWords; i++) begin
                imem[i] = prog[i];
            end
            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            // state straight out of reset
            @(negedge clk);
            checkAddr($sformatf("prog%0d reset icacheAddr", p), '0, icacheAddr);
            checkFlag($sformatf("prog%0d reset dcacheRen", p), 1'b0, dcacheRen);
            checkFlag($sformatf("prog%0d reset dcacheWen", p), 1'b0, dcacheWen);
            cycles = 0;
            while (!haltSeen && cycles < ProgCycles - 20) begin
                @(posedge clk);
                cycles++;
            end
            if (!haltSeen) begin
                $display("program %0d: no final dump store within %0d cycles", p, cycles);
                errorCount++;
                progErrors++;
            end
            compareStores(p);
            if (progErrors == 0) begin
                $display("program %0d passed: %0d stores in %0d cycles",
                         p, capAddr.size(), cycles);
            end else begin
                $display("program %0d failed with %0d errors", p, progErrors);
                failedPrograms++;
            end
        end
        $display("programs: %0d, failed: %0d, checks: %0d, errors: %0d",
                 NumPrograms, failedPrograms, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run limit from the program count and per-program budget
    initial begin : watchdog
        #(NumPrograms * ProgCycles * ClkPeriod);
        $display("watchdog: the run did not finish within %0d ns",
                 NumPrograms * ProgCycles * ClkPeriod);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+testbench
src/mipsPkg.sv
src/registerFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/memWriteback.sv
src/mipsPipeline.sv
testbench/tbMips.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMips
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "failure reported, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
